//--- video_timing_pkg.sv
/*
 * Video timing definitions shared by the format table and the sync generator.
 * Holds the CEA format ids, the timing record layout and both format records.
 */

package video_timing_pkg;

    typedef logic [7:0]  format_id_t;   // CEA video format number
    typedef logic [11:0] coord_t;       // Counter and timing field width

    localparam format_id_t FORMAT_640X480P60 = 8'd1;
    localparam format_id_t FORMAT_720X480P60 = 8'd2;

    // Full line and frame geometry for one progressive format
    typedef struct packed {
        coord_t h_active;
        coord_t h_fp;
        coord_t h_sync;
        coord_t h_bp;
        coord_t h_total;
        coord_t v_active;
        coord_t v_fp;
        coord_t v_sync;
        coord_t v_bp;
        coord_t v_total;
        logic   sync_pol;               // 0 = active-low hs and vs
    } timing_t;

    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
    } sync_t;

    // Blanking level with active-low sync
    localparam sync_t SYNC_IDLE = '{de: 1'b0, hs: 1'b1, vs: 1'b1};

    // ==============================
    // Format records
    // ==============================
    localparam timing_t TIMING_640X480P60 = '{
        h_active: 12'd640, h_fp: 12'd16, h_sync: 12'd96, h_bp: 12'd48, h_total: 12'd800,
        v_active: 12'd480, v_fp: 12'd10, v_sync: 12'd2,  v_bp: 12'd33, v_total: 12'd525,
        sync_pol: 1'b0
    };

    localparam timing_t TIMING_720X480P60 = '{
        h_active: 12'd720, h_fp: 12'd16, h_sync: 12'd62, h_bp: 12'd60, h_total: 12'd858,
        v_active: 12'd480, v_fp: 12'd9,  v_sync: 12'd6,  v_bp: 12'd30, v_total: 12'd525,
        sync_pol: 1'b0
    };

endpackage

//--- pixel_pkg.sv
/*
 * Pixel data definitions for the pattern source, pixel FIFO and output stage.
 * The video output word bundles sync with colour as it leaves for the HDMI port.
 */

package pixel_pkg;

    // 24-bit RGB, red in the top byte as on the transmitter data bus
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // ==============================
    // Colour constants
    // ==============================
    localparam pixel_t COLOR_RED   = '{r: 8'hff, g: 8'h00, b: 8'h00};
    localparam pixel_t COLOR_BLUE  = '{r: 8'h00, g: 8'h00, b: 8'hff};
    localparam pixel_t COLOR_BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};

    localparam int FIFO_DEPTH = 16;     // Pixel FIFO entries

    // Word driven onto the HDMI transmitter pins
    typedef struct packed {
        video_timing_pkg::sync_t sync;
        pixel_t                  rgb;
    } video_out_t;

endpackage

//--- video_format_table.sv
/*
 * Decodes the requested CEA format id into a timing record for the sync
 * generator. The record only changes at frame start, so a frame never mixes
 * two formats. Unknown ids leave the current format in place.
 */

`timescale 1ns/1ns

module video_format_table (
    input  logic                         clk_25_2m,
    input  logic                         reset,         // Sync, active low
    input  video_timing_pkg::format_id_t video_format,  // Requested format
    input  logic                         frame_start,   // Counters at 0,0
    output video_timing_pkg::timing_t    timing         // Active record
);

    // ==============================
    // Record register
    // ==============================
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            timing <= video_timing_pkg::TIMING_640X480P60; // Format 1 out of reset
        end else if (frame_start) begin
            case (video_format)
                video_timing_pkg::FORMAT_640X480P60:
                    timing <= video_timing_pkg::TIMING_640X480P60;
                video_timing_pkg::FORMAT_720X480P60:
                    timing <= video_timing_pkg::TIMING_720X480P60;
                default: ;                  // Unsupported id, hold current
            endcase
        end
    end

    // Format switch must land on a frame boundary
    a_timing_frame_aligned : assert property (
        @(posedge clk_25_2m) disable iff (!reset)
        !frame_start |=> $stable(timing)
    ) else $error("timing record changed outside frame start");

endmodule

//--- video_sync_gen.sv
/*
 * Horizontal and vertical raster counters for progressive video.
 * Produces registered de, hs and vs one cycle behind the counters, plus a
 * frame_start pulse while both counters are zero.
 */

`timescale 1ns/1ns

module video_sync_gen (
    input  logic                      clk_25_2m,
    input  logic                      reset,        // Sync, active low
    input  video_timing_pkg::timing_t timing,       // From format table
    output video_timing_pkg::sync_t   sync,         // Registered de/hs/vs
    output logic                      frame_start   // First pixel of frame
);

    video_timing_pkg::coord_t h_cnt;            // Pixel within line
    video_timing_pkg::coord_t v_cnt;            // Line within frame
    video_timing_pkg::coord_t hs_start;
    video_timing_pkg::coord_t hs_end;
    video_timing_pkg::coord_t vs_start;
    video_timing_pkg::coord_t vs_end;
    logic                     h_last;
    logic                     v_last;
    logic                     de_next;
    logic                     hs_active;
    logic                     vs_active;

    // ==============================
    // Raster counters
    // ==============================
    assign h_last = (h_cnt == timing.h_total - 12'd1);
    assign v_last = (v_cnt == timing.v_total - 12'd1);

    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 12'd1; // Next line or wrap frame
        end else begin
            h_cnt <= h_cnt + 12'd1;
        end
    end

    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

    // ==============================
    // Sync decode
    // ==============================
    // Line order is active, front porch, sync, back porch
    assign hs_start = timing.h_active + timing.h_fp;
    assign hs_end   = hs_start + timing.h_sync;
    assign vs_start = timing.v_active + timing.v_fp;
    assign vs_end   = vs_start + timing.v_sync;

    assign de_next   = (h_cnt < timing.h_active) && (v_cnt < timing.v_active);
    assign hs_active = (h_cnt >= hs_start) && (h_cnt < hs_end);
    assign vs_active = (v_cnt >= vs_start) && (v_cnt < vs_end); // Whole lines

    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            sync <= video_timing_pkg::SYNC_IDLE;  // Blank, sync inactive
        end else begin
            sync.de <= de_next;
            // Polarity bit gives the asserted level
            sync.hs <= hs_active ? timing.sync_pol : ~timing.sync_pol;
            sync.vs <= vs_active ? timing.sync_pol : ~timing.sync_pol;
        end
    end

    // hs pulse sits in horizontal blanking only
    a_de_hs_exclusive : assert property (
        @(posedge clk_25_2m) disable iff (!reset)
        !(sync.de && (sync.hs == timing.sync_pol))
    ) else $error("de and hs active in the same cycle");

endmodule

//--- pattern_source.sv
/*
 * Test pixel writer standing in for a camera. Pushes alternating red and
 * blue pixels into the pixel FIFO while enabled and the FIFO has room.
 */

`timescale 1ns/1ns

module pattern_source (
    input  logic              clk_25_2m,
    input  logic              reset,          // Sync, active low
    input  logic              pattern_enable, // Level, gates the writer
    input  logic              full,           // FIFO back-pressure
    output logic              wr_en,          // FIFO write strobe
    output pixel_pkg::pixel_t wr_data         // Pixel to write
);

    logic send_blue;                        // 0 = red next, 1 = blue next

    // One pixel per cycle, stalled only by full
    assign wr_en   = reset && pattern_enable && !full; // Quiet in reset
    assign wr_data = send_blue ? pixel_pkg::COLOR_BLUE : pixel_pkg::COLOR_RED;

    // ==============================
    // Colour toggle
    // ==============================
    // Advances only on an accepted write so pauses keep the sequence
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            send_blue <= 1'b0;              // First pixel red
        end else if (wr_en) begin
            send_blue <= ~send_blue;
        end
    end

endmodule

//--- pixel_fifo.sv
/*
 * Single-clock first-word-fall-through FIFO for 24-bit pixels.
 * rd_data shows the head entry combinationally, rd_en pops it at the edge.
 */

`timescale 1ns/1ns

module pixel_fifo #(
    parameter int DEPTH = pixel_pkg::FIFO_DEPTH
) (
    input  logic              clk_25_2m,
    input  logic              reset,      // Sync, active low
    input  logic              wr_en,      // Push strobe
    input  pixel_pkg::pixel_t wr_data,
    input  logic              rd_en,      // Pop strobe
    output pixel_pkg::pixel_t rd_data,    // Head entry
    output logic              full,
    output logic              empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    pixel_pkg::pixel_t mem [DEPTH];         // Storage
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;               // Entries held

    // ==============================
    // Storage and pointers
    // ==============================
    always_ff @(posedge clk_25_2m) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;              // Level unchanged on idle or push and pop
            endcase
        end
    end

    assign rd_data = mem[rd_ptr];           // Fall-through head word
    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);

    a_no_write_when_full : assert property (
        @(posedge clk_25_2m) disable iff (!reset) wr_en |-> !full
    ) else $error("pixel FIFO overflow");

    a_no_read_when_empty : assert property (
        @(posedge clk_25_2m) disable iff (!reset) rd_en |-> !empty
    ) else $error("pixel FIFO underflow");

endmodule

//--- pixel_out.sv
/*
 * Video output stage. Pops one pixel per active cycle and registers it with
 * its sync for the HDMI transmitter. Blanking and starved cycles go out black,
 * and a starved active cycle sets the sticky underrun flag.
 */

`timescale 1ns/1ns

module pixel_out (
    input  logic                    clk_25_2m,
    input  logic                    reset,      // Sync, active low
    input  video_timing_pkg::sync_t sync,       // From sync generator
    input  pixel_pkg::pixel_t       rd_data,    // FIFO head word
    input  logic                    empty,
    output logic                    rd_en,      // FIFO pop strobe
    output pixel_pkg::video_out_t   video,      // Registered HDMI word
    output logic                    underrun    // Sticky until reset
);

    pixel_pkg::pixel_t rgb_next;

    // Pop whenever the display wants a pixel and one is there
    assign rd_en    = sync.de && !empty;
    assign rgb_next = rd_en ? rd_data : pixel_pkg::COLOR_BLACK;

    // ==============================
    // Output register
    // ==============================
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            video.sync <= video_timing_pkg::SYNC_IDLE;
            video.rgb  <= pixel_pkg::COLOR_BLACK;
            underrun   <= 1'b0;
        end else begin
            video.sync <= sync;             // Sync travels with its pixel
            video.rgb  <= rgb_next;
            if (sync.de && empty) begin
                underrun <= 1'b1;           // Display starved
            end
        end
    end

endmodule

//--- video_top.sv
/*
 * Top level of the test video path. Format table and sync generator build the
 * raster, the pattern source fills the pixel FIFO and the output stage drains
 * it in step with the sync, two cycles behind the raster counters.
 */

`timescale 1ns/1ns

module video_top (
    input  logic                         clk_25_2m,
    input  logic                         reset,          // Sync, active low
    input  video_timing_pkg::format_id_t video_format,   // CEA format id
    input  logic                         pattern_enable, // Test source on
    output pixel_pkg::video_out_t        video,          // To HDMI transmitter
    output logic                         underrun        // Sticky starve flag
);

    video_timing_pkg::timing_t timing;
    video_timing_pkg::sync_t   sync;
    logic                      frame_start;
    logic                      wr_en;
    pixel_pkg::pixel_t         wr_data;
    logic                      full;
    logic                      rd_en;
    pixel_pkg::pixel_t         rd_data;
    logic                      empty;

    // ==============================
    // Raster timing
    // ==============================
    video_format_table u_format_table (
        .clk_25_2m    (clk_25_2m),
        .reset        (reset),
        .video_format (video_format),
        .frame_start  (frame_start),
        .timing       (timing)
    );

    video_sync_gen u_sync_gen (
        .clk_25_2m   (clk_25_2m),
        .reset       (reset),
        .timing      (timing),
        .sync        (sync),
        .frame_start (frame_start)
    );

    // ==============================
    // Pixel path
    // ==============================
    pattern_source u_pattern (
        .clk_25_2m      (clk_25_2m),
        .reset          (reset),
        .pattern_enable (pattern_enable),
        .full           (full),
        .wr_en          (wr_en),
        .wr_data        (wr_data)
    );

    pixel_fifo #(.DEPTH(pixel_pkg::FIFO_DEPTH)) u_fifo (
        .clk_25_2m (clk_25_2m),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .full      (full),
        .empty     (empty)
    );

    pixel_out u_out (
        .clk_25_2m (clk_25_2m),
        .reset     (reset),
        .sync      (sync),
        .rd_data   (rd_data),
        .empty     (empty),
        .rd_en     (rd_en),
        .video     (video),
        .underrun  (underrun)
    );

endmodule

//--- tb_video_top.sv
/*
 * Directed testbench for the test video path. Drives video_top through reset,
 * line and frame timing, the red and blue pattern, a format switch and source
 * pauses that starve the FIFO. Outputs are sampled 1 ns after each rising edge.
 */

`timescale 1ns/1ns

module tb_video_top;

    typedef video_timing_pkg::coord_t coord_t;

    localparam int TIMEOUT_CYCLES = 6 * 858 * 525 + 10_000; // Six widest frames plus slack
    localparam video_timing_pkg::sync_t SYNC_BLANK = '{de: 1'b0, hs: 1'b1, vs: 1'b1};

    logic                         clk_25_2m = 1'b0;
    logic                         reset;
    video_timing_pkg::format_id_t video_format;
    logic                         pattern_enable;
    pixel_pkg::video_out_t        video;
    logic                         underrun;

    int          cycle_count = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr_state = 32'h1e1a_0ada;
    logic        expect_blue;           // Next coloured pixel is blue
    int          black_de_count;        // Starved active pixels seen
    int          colour_count;          // Red or blue pixels seen

    video_top dut_i (
        .clk_25_2m      (clk_25_2m),
        .reset          (reset),
        .video_format   (video_format),
        .pattern_enable (pattern_enable),
        .video          (video),
        .underrun       (underrun)
    );

    always #5 clk_25_2m = ~clk_25_2m;   // 10 ns period

    // Run limit
    always @(posedge clk_25_2m) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ==============================
    // Compare tasks
    // ==============================
    task automatic compare_pixel(input pixel_pkg::pixel_t got, input pixel_pkg::pixel_t exp,
                                 input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_sync(input video_timing_pkg::sync_t got,
                                input video_timing_pkg::sync_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_count(input coord_t got, input coord_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        error_count += test_errors;
        if (test_errors != 0) tests_failed++;
        $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        test_errors = 0;
    endtask

    // ==============================
    // Stimulus helpers
    // ==============================
    // Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        repeat (n) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);     // One step per bit
        end
    endtask

    task automatic tick();
        @(posedge clk_25_2m);
        #1;                             // Drive and sample point
    endtask

    // One cycle with the pattern rules applied to the output word
    task automatic tick_checked();
        tick();
        if (!video.sync.de) begin
            compare_pixel(video.rgb, pixel_pkg::COLOR_BLACK, "blanking pixel");
        end else if (video.rgb == pixel_pkg::COLOR_BLACK) begin
            black_de_count++;           // Starved pixel
        end else begin
            compare_pixel(video.rgb, expect_blue ? pixel_pkg::COLOR_BLUE : pixel_pkg::COLOR_RED,
                          "pattern pixel");
            expect_blue = ~expect_blue;
            colour_count++;
        end
    endtask

    task automatic apply_reset(input video_timing_pkg::format_id_t fmt, input logic enable);
        reset          = 1'b0;
        video_format   = fmt;
        pattern_enable = enable;
        repeat (16) tick();
        reset          = 1'b1;
        expect_blue    = 1'b0;          // Red comes first
        black_de_count = 0;
        colour_count   = 0;
    endtask

    // Times the line after the next de rise, in output cycles
    task automatic measure_line(input coord_t active, input coord_t fp, input coord_t sync_len,
                                input coord_t total);
        int de_len = 0;
        int hs_delay = 0;
        int hs_len = 0;
        int period;
        while (video.sync.de) tick();
        while (!video.sync.de) tick();
        while (video.sync.de) begin
            de_len++;
            tick();
        end
        while (video.sync.hs) begin
            hs_delay++;                 // Front porch
            tick();
        end
        while (!video.sync.hs) begin
            hs_len++;
            tick();
        end
        period = de_len + hs_delay + hs_len;
        while (!video.sync.de) begin
            period++;                   // Back porch up to the next line
            tick();
        end
        compare_count(coord_t'(de_len), active, "de high run");
        compare_count(coord_t'(hs_delay), fp, "de fall to hs fall");
        compare_count(coord_t'(hs_len), sync_len, "hs low run");
        compare_count(coord_t'(period), total, "line period");
    endtask

    task automatic wait_vs_fall();
        while (!video.sync.vs) tick();
        while (video.sync.vs) tick();
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset_values();
        reset          = 1'b0;
        video_format   = video_timing_pkg::FORMAT_640X480P60;
        pattern_enable = 1'b0;
        for (int i = 0; i < 17; i++) begin
            if (i == 16) reset = 1'b1;  // Last pass is the first cycle out of reset
            tick();
            compare_sync(video.sync, SYNC_BLANK, "idle sync");
            compare_pixel(video.rgb, pixel_pkg::COLOR_BLACK, "idle rgb");
            compare_flag(underrun, 1'b0, "idle underrun");
        end
        finish_test("reset_values");
    endtask

    task automatic test_line_timing();
        apply_reset(video_timing_pkg::FORMAT_640X480P60, 1'b1);
        measure_line(12'd640, 12'd16, 12'd96, 12'd800);
        measure_line(12'd640, 12'd16, 12'd96, 12'd800);
        finish_test("line_timing");
    endtask

    // Positions count output cycles from the first active pixel of the frame
    task automatic test_frame_timing();
        int   pos = 0;
        int   de_lines = 1;
        int   last_de_pos = 0;
        int   vs_fall = -1;
        int   vs_rise = -1;
        logic prev_de = 1'b1;
        logic prev_vs = 1'b1;
        apply_reset(video_timing_pkg::FORMAT_640X480P60, 1'b0);
        while (!video.sync.de) tick();
        while (!(vs_rise >= 0 && video.sync.de)) begin
            tick();
            pos++;
            if (video.sync.de && vs_rise < 0) begin
                if (!prev_de) de_lines++;
                last_de_pos = pos;
            end
            if (!video.sync.vs && prev_vs) vs_fall = pos;
            if (video.sync.vs && !prev_vs) vs_rise = pos;
            prev_de = video.sync.de;
            prev_vs = video.sync.vs;
        end
        compare_count(coord_t'(de_lines), 12'd480, "active lines per frame");
        compare_count(coord_t'(vs_fall / 800 - last_de_pos / 800 - 1), 12'd10,
                      "lines from last active line to vs");
        compare_count(coord_t'(vs_fall % 800), 12'd0, "vs fall offset in line");
        compare_count(coord_t'((vs_rise - vs_fall) / 800), 12'd2, "vs low lines");
        compare_count(coord_t'((vs_rise - vs_fall) % 800), 12'd0, "vs low remainder");
        compare_count(coord_t'(pos / 800), 12'd525, "lines per frame");
        compare_count(coord_t'(pos % 800), 12'd0, "frame length remainder");
        finish_test("frame_timing");
    endtask

    task automatic test_pattern_frame();
        apply_reset(video_timing_pkg::FORMAT_640X480P60, 1'b1);
        repeat (525 * 800 + 2) tick_checked();  // Whole first frame at the output
        compare_flag(underrun, 1'b0, "underrun after a full frame");
        if (black_de_count != 0) report_failure("black pixels with de high while source kept up");
        if (colour_count < 640 * 480) report_failure("fewer coloured pixels than one frame holds");
        finish_test("pattern_frame");
    endtask

    task automatic test_format_switch();
        apply_reset(video_timing_pkg::FORMAT_640X480P60, 1'b1);
        repeat (100) begin
            while (video.sync.de) tick();
            while (!video.sync.de) tick();
        end
        video_format = video_timing_pkg::FORMAT_720X480P60;    // Mid frame request
        measure_line(12'd640, 12'd16, 12'd96, 12'd800);         // Current frame unchanged
        wait_vs_fall();
        measure_line(12'd720, 12'd16, 12'd62, 12'd858);
        video_format = video_timing_pkg::format_id_t'(7);       // Unsupported id
        wait_vs_fall();
        measure_line(12'd720, 12'd16, 12'd62, 12'd858);
        video_format = video_timing_pkg::FORMAT_640X480P60;
        finish_test("format_switch");
    endtask

    task automatic test_pause_underrun();
        int span;
        apply_reset(video_timing_pkg::FORMAT_640X480P60, 1'b1);
        for (int line = 0; line < 6; line++) begin
            while (video.sync.de) tick_checked();
            while (!video.sync.de) tick_checked();
            if (line == 0) compare_flag(underrun, 1'b0, "underrun before any pause");
            if (line < 4) begin
                take_bits(5, span);
                span = span + pixel_pkg::FIFO_DEPTH + 2;    // Longer than the FIFO covers
                pattern_enable = 1'b0;
                repeat (span) tick_checked();
                pattern_enable = 1'b1;
            end
        end
        while (video.sync.de) tick_checked();
        compare_flag(underrun, 1'b1, "underrun after source pauses");
        if (black_de_count == 0) report_failure("no black pixels with de high during pauses");
        if (colour_count == 0) report_failure("no coloured pixels after the pauses");
        finish_test("pause_underrun");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        reset          = 1'b0;
        video_format   = video_timing_pkg::FORMAT_640X480P60;
        pattern_enable = 1'b0;
        test_reset_values();
        test_line_timing();
        test_frame_timing();
        test_pattern_frame();
        test_format_switch();
        test_pause_underrun();
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
video_timing_pkg.sv
pixel_pkg.sv
video_format_table.sv
video_sync_gen.sv
pattern_source.sv
pixel_fifo.sv
pixel_out.sv
video_top.sv
tb_video_top.sv

//--- Makefile
# Verilator build and run for the test video path

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_video_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
